// ==== include/csrUnit_params.svh ====
/*
 * Sizing for the machine-mode CSR block.
 * The data width is fixed at 32 bits. Wider values are not supported by the mip layout.
 * CSR_COMMIT_WIDTH bounds how many instructions can retire in one cycle.
 */
`ifndef CSR_UNIT_PARAMS_SVH
`define CSR_UNIT_PARAMS_SVH

// Register width in bits
`define CSR_DATA_WIDTH 32

// Width of the retired-instruction count per cycle, so up to 3 per cycle
`define CSR_COMMIT_WIDTH 2

// Low address bits of the trap handler that are always zero
`define CSR_MTVEC_ALIGN 2

// Full width of mcycle and minstret
`define CSR_COUNTER_WIDTH (2 * `CSR_DATA_WIDTH)

`endif

// ==== src/csrPkg.sv ====
/*
 * Types for the machine-mode CSR block.
 * Trap causes use the RISC-V exception codes so that they go straight into mcause.
 * mret has its own code, which never reaches mcause.
 */
`include "csrUnit_params.svh"

package csrPkg;

    // Implemented CSR addresses
    typedef enum logic [11:0] {
        csrNumMstatus   = 12'h300,
        csrNumMie       = 12'h304,
        csrNumMtvec     = 12'h305,
        csrNumMscratch  = 12'h340,
        csrNumMepc      = 12'h341,
        csrNumMcause    = 12'h342,
        csrNumMtval     = 12'h343,
        csrNumMip       = 12'h344,
        csrNumMcycle    = 12'hB00,
        csrNumMinstret  = 12'hB02,
        csrNumMcycleh   = 12'hB80,
        csrNumMinstreth = 12'hB82
    } csrNumE;

    typedef enum logic [1:0] {
        csrWrite = 2'd0,
        csrSet   = 2'd1,
        csrClear = 2'd2
    } csrOpE;

    typedef enum logic [3:0] {
        causeInsnMisaligned  = 4'd0,
        causeInsnViolation   = 4'd1,
        causeInsnIllegal     = 4'd2,
        causeEbreak          = 4'd3,
        causeLoadMisaligned  = 4'd4,
        causeLoadViolation   = 4'd5,
        causeStoreMisaligned = 4'd6,
        causeStoreViolation  = 4'd7,
        causeEcall           = 4'd11,
        causeMret            = 4'd15
    } trapCauseE;

    // MIE at bit 3, MPIE at bit 7
    typedef struct packed {
        logic [`CSR_DATA_WIDTH-1:8] upperBits;
        logic                       mpie;
        logic [6:4]                 middleBits;
        logic                       mie;
        logic [2:0]                 lowBits;
    } mstatusT;

    typedef struct packed {
        logic [`CSR_DATA_WIDTH-6:0] reserved;
        logic [3:0]                 code;
    } intrCodeT;

    typedef struct packed {
        logic [`CSR_DATA_WIDTH-6:0] reserved;
        trapCauseE                  code;
    } trapCodeT;

    // Low 31 bits of mcause, read by the isInterrupt bit
    typedef union packed {
        intrCodeT interruptCode;
        trapCodeT trapCode;
    } mcauseCodeU;

    typedef struct packed {
        logic       isInterrupt;
        mcauseCodeU code;
    } mcauseT;

    typedef struct packed {
        logic                       writeEnable;
        csrOpE                      op;
        csrNumE                     number;
        logic [`CSR_DATA_WIDTH-1:0] operand;
    } csrReqT;

    typedef struct packed {
        logic                       triggerExcpt;
        logic                       triggerInterrupt;
        trapCauseE                  cause;
        logic [`CSR_DATA_WIDTH-1:0] causeAddr;
        logic [`CSR_DATA_WIDTH-1:0] dataAddr;
        logic [`CSR_DATA_WIDTH-1:0] interruptRetAddr;
        logic [3:0]                 interruptCode;
    } trapReqT;

    typedef struct packed {
        mstatusT                    mstatus;
        logic [`CSR_DATA_WIDTH-1:0] mie;
        logic [`CSR_DATA_WIDTH-1:0] mip;
        logic [`CSR_DATA_WIDTH-1:0] mtvec;
        logic [`CSR_DATA_WIDTH-1:0] mepc;
    } csrStateT;

endpackage

// ==== src/csrRegFile.sv ====
`timescale 1ns/1ps
/*
 * Machine trap state: mstatus, mie, mip, mcause, mtvec, mtval, mepc, mscratch.
 * Priority is interrupt, then exception, then CSR write. The core keeps them exclusive.
 * mip is read only. mtvec holds direct mode only, so its low bits read as zero.
 */
`include "csrUnit_params.svh"

module csrRegFile import csrPkg::*; (
    input  logic                       clk,
    input  logic                       arstN,
    input  csrReqT                     csrReq,
    input  trapReqT                    trapReq,
    input  logic [`CSR_DATA_WIDTH-1:0] writeValue,
    input  logic                       reqTimerInterrupt,
    input  logic                       reqExternalInterrupt,
    input  logic                       externalInterruptCode,
    output logic [`CSR_DATA_WIDTH-1:0] readData,
    output logic                       readHit,
    output csrStateT                   csrState,
    output logic                       externalInterruptCodeOut
);
    localparam int MtipBit = 7;
    localparam int MeipBit = 11;

    mstatusT                    mstatus;
    mcauseT                     mcause;
    logic [`CSR_DATA_WIDTH-1:0] mie;
    logic [`CSR_DATA_WIDTH-1:0] mtvec;
    logic [`CSR_DATA_WIDTH-1:0] mtval;
    logic [`CSR_DATA_WIDTH-1:0] mepc;
    logic [`CSR_DATA_WIDTH-1:0] mscratch;
    logic [`CSR_DATA_WIDTH-1:0] mipWord;
    logic                       mipTimer;
    logic                       mipExternal;
    logic                       externalCodeReg;

    // Only MTIP and MEIP exist
    always_comb begin
        mipWord = '0;
        mipWord[MtipBit] = mipTimer;
        mipWord[MeipBit] = mipExternal;
    end

    always_comb begin
        readHit = 1'b1;
        case (csrReq.number)
            csrNumMstatus:  readData = mstatus;
            csrNumMie:      readData = mie;
            csrNumMip:      readData = mipWord;
            csrNumMcause:   readData = mcause;
            csrNumMtvec:    readData = mtvec;
            csrNumMtval:    readData = mtval;
            csrNumMepc:     readData = mepc;
            csrNumMscratch: readData = mscratch;
            default: begin
                readData = '0;
                readHit = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mstatus         <= '0;
            mcause          <= '0;
            mie             <= '0;
            mtvec           <= '0;
            mtval           <= '0;
            mepc            <= '0;
            mscratch        <= '0;
            mipTimer        <= 1'b0;
            mipExternal     <= 1'b0;
            externalCodeReg <= 1'b0;
        end else begin
            // Request lines land in mip one cycle later
            mipTimer        <= reqTimerInterrupt;
            mipExternal     <= reqExternalInterrupt;
            externalCodeReg <= externalInterruptCode;

            if (trapReq.triggerInterrupt) begin
                mstatus.mpie <= mstatus.mie;
                mstatus.mie  <= 1'b0;
                mepc         <= trapReq.interruptRetAddr;
                mtval        <= trapReq.interruptRetAddr;
                mcause.isInterrupt <= 1'b1;
                mcause.code.interruptCode.reserved <= '0;
                mcause.code.interruptCode.code <= trapReq.interruptCode;
            end else if (trapReq.triggerExcpt) begin
                if (trapReq.cause == causeMret) begin
                    mstatus.mie <= mstatus.mpie;
                end else begin
                    mstatus.mpie <= mstatus.mie;
                    mstatus.mie  <= 1'b0;
                    mepc         <= trapReq.causeAddr;
                    mtval        <= trapReq.dataAddr;
                    mcause.isInterrupt <= 1'b0;
                    mcause.code.trapCode.reserved <= '0;
                    mcause.code.trapCode.code <= trapReq.cause;
                end
            end else if (csrReq.writeEnable) begin
                case (csrReq.number)
                    csrNumMstatus:  mstatus  <= mstatusT'(writeValue);
                    csrNumMie:      mie      <= writeValue;
                    csrNumMcause:   mcause   <= mcauseT'(writeValue);
                    csrNumMtvec: begin
                        mtvec <= {writeValue[`CSR_DATA_WIDTH-1:`CSR_MTVEC_ALIGN],
                                  {`CSR_MTVEC_ALIGN{1'b0}}};
                    end
                    csrNumMtval:    mtval    <= writeValue;
                    csrNumMepc:     mepc     <= writeValue;
                    csrNumMscratch: mscratch <= writeValue;
                    default: ;
                endcase
            end
        end
    end

    assign csrState = '{mstatus: mstatus, mie: mie, mip: mipWord, mtvec: mtvec, mepc: mepc};
    assign externalInterruptCodeOut = externalCodeReg;

    // Core issues at most one state update per cycle
    assert property (@(posedge clk) disable iff (!arstN)
        $onehot0({trapReq.triggerInterrupt, trapReq.triggerExcpt, csrReq.writeEnable}))
        else $error("Interrupt, exception and CSR write in the same cycle");

    assert property (@(posedge clk) disable iff (!arstN)
        trapReq.triggerExcpt |-> trapReq.cause inside {
            causeInsnMisaligned, causeInsnViolation, causeInsnIllegal, causeEbreak,
            causeLoadMisaligned, causeLoadViolation, causeStoreMisaligned,
            causeStoreViolation, causeEcall, causeMret})
        else $error("Unknown exception cause");

endmodule

// ==== src/csrCounters.sv ====
`timescale 1ns/1ps
/*
 * mcycle and minstret, 64 bits each, read and written as two halves.
 * The commit count is registered, so retired instructions show up one cycle late.
 */
`include "csrUnit_params.svh"

module csrCounters import csrPkg::*; (
    input  logic                        clk,
    input  logic                        arstN,
    input  csrReqT                      csrReq,
    input  logic [`CSR_DATA_WIDTH-1:0]  writeValue,
    input  logic [`CSR_COMMIT_WIDTH-1:0] commitNum,
    output logic [`CSR_DATA_WIDTH-1:0]  readData,
    output logic                        readHit
);
    logic [`CSR_COUNTER_WIDTH-1:0] cycleCnt;
    logic [`CSR_COUNTER_WIDTH-1:0] instretCnt;
    logic [`CSR_COMMIT_WIDTH-1:0]  commitNumReg;
    logic                          writeEn;

    // Increment with carry, then a written half replaces its incremented value
    function automatic logic [`CSR_COUNTER_WIDTH-1:0] nextCount(
        input logic [`CSR_COUNTER_WIDTH-1:0] current,
        input logic [`CSR_COMMIT_WIDTH-1:0]  step,
        input logic                          writeLow,
        input logic                          writeHigh,
        input logic [`CSR_DATA_WIDTH-1:0]    value
    );
        logic [`CSR_COUNTER_WIDTH-1:0] sum;
        sum = current + `CSR_COUNTER_WIDTH'(step);
        if (writeLow) sum[`CSR_DATA_WIDTH-1:0] = value;
        if (writeHigh) sum[`CSR_COUNTER_WIDTH-1:`CSR_DATA_WIDTH] = value;
        return sum;
    endfunction

    assign writeEn = csrReq.writeEnable;

    always_comb begin
        readHit = 1'b1;
        case (csrReq.number)
            csrNumMcycle:    readData = cycleCnt[`CSR_DATA_WIDTH-1:0];
            csrNumMcycleh:   readData = cycleCnt[`CSR_COUNTER_WIDTH-1:`CSR_DATA_WIDTH];
            csrNumMinstret:  readData = instretCnt[`CSR_DATA_WIDTH-1:0];
            csrNumMinstreth: readData = instretCnt[`CSR_COUNTER_WIDTH-1:`CSR_DATA_WIDTH];
            default: begin
                readData = '0;
                readHit = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cycleCnt     <= '0;
            instretCnt   <= '0;
            commitNumReg <= '0;
        end else begin
            commitNumReg <= commitNum;
            cycleCnt <= nextCount(cycleCnt, `CSR_COMMIT_WIDTH'(1),
                writeEn && csrReq.number == csrNumMcycle,
                writeEn && csrReq.number == csrNumMcycleh, writeValue);
            instretCnt <= nextCount(instretCnt, commitNumReg,
                writeEn && csrReq.number == csrNumMinstret,
                writeEn && csrReq.number == csrNumMinstreth, writeValue);
        end
    end

endmodule

// ==== src/csrAccessMerge.sv ====
`timescale 1ns/1ps
/*
 * Combinational glue between the register file and the counter bank.
 * The read word feeds the set and clear forms, so the write value is ready in the same cycle.
 * An unimplemented CSR number reads as zero.
 */
`include "csrUnit_params.svh"

module csrAccessMerge import csrPkg::*; (
    input  logic                       assertClk,
    input  csrReqT                     csrReq,
    input  trapReqT                    trapReq,
    input  logic [`CSR_DATA_WIDTH-1:0] regReadData,
    input  logic                       regReadHit,
    input  logic [`CSR_DATA_WIDTH-1:0] cntReadData,
    input  logic                       cntReadHit,
    input  csrStateT                   csrState,
    output logic [`CSR_DATA_WIDTH-1:0] writeValue,
    output logic [`CSR_DATA_WIDTH-1:0] csrReadOut,
    output logic [`CSR_DATA_WIDTH-1:0] trapTarget,
    output logic                       interruptPending
);
    logic [`CSR_DATA_WIDTH-1:0] readWord;
    logic [`CSR_DATA_WIDTH-1:0] handlerBase;

    always_comb begin
        if (regReadHit) begin
            readWord = regReadData;
        end else if (cntReadHit) begin
            readWord = cntReadData;
        end else begin
            readWord = '0;
        end
    end

    assign csrReadOut = readWord;

    // Read-modify-write forms
    always_comb begin
        case (csrReq.op)
            csrWrite: writeValue = csrReq.operand;
            csrSet:   writeValue = readWord | csrReq.operand;
            csrClear: writeValue = readWord & ~csrReq.operand;
            default:  writeValue = csrReq.operand;
        endcase
    end

    // Direct mode only
    assign handlerBase = {csrState.mtvec[`CSR_DATA_WIDTH-1:`CSR_MTVEC_ALIGN],
                          {`CSR_MTVEC_ALIGN{1'b0}}};

    assign trapTarget = (trapReq.cause == causeMret) ? csrState.mepc : handlerBase;

    // Global enable gates any enabled pending source
    assign interruptPending = csrState.mstatus.mie & (|(csrState.mip & csrState.mie));

    // Register file and counter bank decode disjoint numbers
    assert property (@(posedge assertClk) !(regReadHit && cntReadHit))
        else $error("Register file and counter bank both claim CSR %h", csrReq.number);

endmodule

// ==== src/csrUnit.sv ====
`timescale 1ns/1ps
/*
 * Machine-mode CSR block for a small RISC-V style core.
 * One CSR access per cycle, read in the same cycle, written at the next edge.
 * No handshake: every request completes in its own cycle.
 */
`include "csrUnit_params.svh"

module csrUnit import csrPkg::*; (
    input  logic                         clk,
    input  logic                         arstN,
    input  csrReqT                       csrReq,
    input  trapReqT                      trapReq,
    input  logic [`CSR_COMMIT_WIDTH-1:0] commitNum,
    input  logic                         reqTimerInterrupt,
    input  logic                         reqExternalInterrupt,
    input  logic                         externalInterruptCode,
    output logic [`CSR_DATA_WIDTH-1:0]   csrReadOut,
    output logic [`CSR_DATA_WIDTH-1:0]   trapTarget,
    output logic                         interruptPending,
    output logic                         externalInterruptCodeOut
);
    logic [`CSR_DATA_WIDTH-1:0] regReadData;
    logic                       regReadHit;
    logic [`CSR_DATA_WIDTH-1:0] cntReadData;
    logic                       cntReadHit;
    logic [`CSR_DATA_WIDTH-1:0] writeValue;
    csrStateT                   csrState;

    csrRegFile regFile_i (
        .clk(clk), .arstN(arstN), .csrReq(csrReq), .trapReq(trapReq),
        .writeValue(writeValue), .reqTimerInterrupt(reqTimerInterrupt),
        .reqExternalInterrupt(reqExternalInterrupt),
        .externalInterruptCode(externalInterruptCode),
        .readData(regReadData), .readHit(regReadHit), .csrState(csrState),
        .externalInterruptCodeOut(externalInterruptCodeOut)
    );

    csrCounters counters_i (
        .clk(clk), .arstN(arstN), .csrReq(csrReq), .writeValue(writeValue),
        .commitNum(commitNum), .readData(cntReadData), .readHit(cntReadHit)
    );

    csrAccessMerge merge_i (
        .assertClk(clk), .csrReq(csrReq), .trapReq(trapReq),
        .regReadData(regReadData), .regReadHit(regReadHit),
        .cntReadData(cntReadData), .cntReadHit(cntReadHit), .csrState(csrState),
        .writeValue(writeValue), .csrReadOut(csrReadOut), .trapTarget(trapTarget),
        .interruptPending(interruptPending)
    );

endmodule

// ==== testbench/csrUnitTb.sv ====
`timescale 1ns/1ps
/*
 * Random-stimulus testbench for csrUnit with its own model of every register and counter.
 * All four outputs are compared with the model in every cycle, whatever the test drives.
 * Stimulus never puts a trap, an interrupt and a CSR write in the same cycle.
 */
`include "csrUnit_params.svh"

module csrUnitTb import csrPkg::*; ();
    localparam int MieBit = 3;
    localparam int MpieBit = 7;
    // Cycles per test, from the loop counts below
    localparam int WriteOpsCycles = 80;
    localparam int TrapCycles = 56;
    localparam int MretCycles = 32;
    localparam int InterruptCycles = 140;
    localparam int CounterCycles = 42;
    localparam int UnimplCycles = 28;
    localparam int CycleLimit = 4 + WriteOpsCycles + TrapCycles + MretCycles
        + InterruptCycles + CounterCycles + UnimplCycles + 100;

    logic                         clk;
    logic                         arstN;
    csrReqT                       csrReq;
    trapReqT                      trapReq;
    logic [`CSR_COMMIT_WIDTH-1:0] commitNum;
    logic                         reqTimerInterrupt;
    logic                         reqExternalInterrupt;
    logic                         externalInterruptCode;
    logic [`CSR_DATA_WIDTH-1:0]   csrReadOut;
    logic [`CSR_DATA_WIDTH-1:0]   trapTarget;
    logic                         interruptPending;
    logic                         externalInterruptCodeOut;

    // Reference model
    logic [31:0] mStatus, mMie, mMtvec, mMepc, mMscratch, mMtval, mMcause;
    logic [63:0] mCycle, mInstret;
    logic [1:0]  mCommitReg;
    logic        mTimer, mExt, mExtCode;

    integer seed = 60;
    int     errorCount = 0;
    int     checkCount = 0;
    int     testCount = 0;
    int     failedTests = 0;
    int     cycleCount = 0;

    csrUnit csrUnit_i (
        .clk(clk), .arstN(arstN), .csrReq(csrReq), .trapReq(trapReq),
        .commitNum(commitNum), .reqTimerInterrupt(reqTimerInterrupt),
        .reqExternalInterrupt(reqExternalInterrupt),
        .externalInterruptCode(externalInterruptCode), .csrReadOut(csrReadOut),
        .trapTarget(trapTarget), .interruptPending(interruptPending),
        .externalInterruptCodeOut(externalInterruptCodeOut)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CycleLimit) begin
            $display("Timeout: the run went past %0d cycles without finishing", CycleLimit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [31:0] randomWord();
        return 32'($random(seed));
    endfunction

    function automatic csrOpE randomOp();
        return csrOpE'(2'(randomWord() % 32'd3));
    endfunction

    // Only MTIP (bit 7) and MEIP (bit 11)
    function automatic logic [31:0] modelMip();
        return (32'(mTimer) << 7) | (32'(mExt) << 11);
    endfunction

    function automatic logic [31:0] modelRead(input logic [11:0] number);
        case (number)
            csrNumMstatus:   return mStatus;
            csrNumMie:       return mMie;
            csrNumMip:       return modelMip();
            csrNumMcause:    return mMcause;
            csrNumMtvec:     return mMtvec;
            csrNumMtval:     return mMtval;
            csrNumMepc:      return mMepc;
            csrNumMscratch:  return mMscratch;
            csrNumMcycle:    return mCycle[31:0];
            csrNumMcycleh:   return mCycle[63:32];
            csrNumMinstret:  return mInstret[31:0];
            csrNumMinstreth: return mInstret[63:32];
            default:         return '0;
        endcase
    endfunction

    // First four are the targets of the write test
    function automatic logic [11:0] stateReg(input int index);
        case (index)
            0: return csrNumMscratch;
            1: return csrNumMtvec;
            2: return csrNumMie;
            3: return csrNumMepc;
            4: return csrNumMstatus;
            5: return csrNumMcause;
            6: return csrNumMtval;
            default: return csrNumMip;
        endcase
    endfunction

    function automatic trapCauseE pickCause(input int index);
        case (index)
            0: return causeInsnMisaligned;
            1: return causeInsnViolation;
            2: return causeInsnIllegal;
            3: return causeEbreak;
            4: return causeLoadMisaligned;
            5: return causeLoadViolation;
            6: return causeStoreMisaligned;
            7: return causeStoreViolation;
            default: return causeEcall;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        assert (got === expected) else begin
            $display("Mismatch %s: got %h, expected %h", name, got, expected);
            errorCount++;
        end
    endtask

    task automatic trapModel(input logic [31:0] pc, input logic [31:0] value,
                             input logic [31:0] cause);
        mStatus[MpieBit] = mStatus[MieBit];
        mStatus[MieBit] = 1'b0;
        mMepc = pc;
        mMtval = value;
        mMcause = cause;
    endtask

    // Next state at the coming rising edge, from the inputs driven now
    task automatic updateModel();
        logic [31:0] wv;
        logic [63:0] nextCycle;
        logic [63:0] nextInstret;
        case (csrReq.op)
            csrSet:   wv = modelRead(csrReq.number) | csrReq.operand;
            csrClear: wv = modelRead(csrReq.number) & ~csrReq.operand;
            default:  wv = csrReq.operand;
        endcase
        nextCycle = mCycle + 64'd1;
        nextInstret = mInstret + 64'(mCommitReg);
        if (csrReq.writeEnable) begin
            case (csrReq.number)
                csrNumMcycle:    nextCycle[31:0] = wv;
                csrNumMcycleh:   nextCycle[63:32] = wv;
                csrNumMinstret:  nextInstret[31:0] = wv;
                csrNumMinstreth: nextInstret[63:32] = wv;
                default: ;
            endcase
        end
        if (trapReq.triggerInterrupt) begin
            trapModel(trapReq.interruptRetAddr, trapReq.interruptRetAddr,
                      {1'b1, 27'b0, trapReq.interruptCode});
        end else if (trapReq.triggerExcpt && trapReq.cause == causeMret) begin
            mStatus[MieBit] = mStatus[MpieBit];
        end else if (trapReq.triggerExcpt) begin
            trapModel(trapReq.causeAddr, trapReq.dataAddr, {1'b0, 27'b0, trapReq.cause});
        end else if (csrReq.writeEnable) begin
            case (csrReq.number)
                csrNumMstatus:  mStatus = wv;
                csrNumMie:      mMie = wv;
                csrNumMcause:   mMcause = wv;
                csrNumMtvec:    mMtvec = {wv[31:`CSR_MTVEC_ALIGN], {`CSR_MTVEC_ALIGN{1'b0}}};
                csrNumMtval:    mMtval = wv;
                csrNumMepc:     mMepc = wv;
                csrNumMscratch: mMscratch = wv;
                default: ;
            endcase
        end
        mTimer = reqTimerInterrupt;
        mExt = reqExternalInterrupt;
        mExtCode = externalInterruptCode;
        mCycle = nextCycle;
        mInstret = nextInstret;
        mCommitReg = commitNum;
    endtask

    // Check all outputs mid-cycle, then advance to the next falling edge
    task automatic cycleStep();
        logic [31:0] target;
        logic        pending;
        #10;
        target = (trapReq.cause == causeMret) ? mMepc :
            {mMtvec[31:`CSR_MTVEC_ALIGN], {`CSR_MTVEC_ALIGN{1'b0}}};
        pending = mStatus[MieBit] & (|(modelMip() & mMie));
        checkValue("csrReadOut", csrReadOut, modelRead(csrReq.number));
        checkValue("trapTarget", trapTarget, target);
        checkValue("interruptPending", {31'b0, interruptPending}, {31'b0, pending});
        checkValue("externalInterruptCodeOut", {31'b0, externalInterruptCodeOut},
                   {31'b0, mExtCode});
        updateModel();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic driveIdle();
        csrReq = '0;
        csrReq.number = csrNumMscratch;
        trapReq = '0;
        trapReq.cause = causeEcall;
    endtask

    task automatic access(input logic writeEnable, input csrOpE op,
                          input logic [11:0] number, input logic [31:0] operand);
        driveIdle();
        csrReq.writeEnable = writeEnable;
        csrReq.op = op;
        csrReq.number = csrNumE'(number);
        csrReq.operand = operand;
        cycleStep();
    endtask

    task automatic readCsr(input logic [11:0] number);
        access(1'b0, csrWrite, number, '0);
    endtask

    task automatic trapEntry();
        driveIdle();
        trapReq.triggerExcpt = 1'b1;
        trapReq.cause = pickCause(int'(randomWord() % 32'd9));
        trapReq.causeAddr = randomWord();
        trapReq.dataAddr = randomWord();
        cycleStep();
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("test %s: ok", name);
        end else begin
            failedTests++;
            $display("test %s: failed with %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    task automatic writeOpsTest();
        int errorsBefore;
        logic [11:0] number;
        errorsBefore = errorCount;
        for (int i = 0; i < 40; i++) begin
            number = stateReg(int'(randomWord() % 32'd4));
            access(1'b1, randomOp(), number, randomWord());
            readCsr(number);
        end
        reportTest("write, set and clear", errorsBefore);
    endtask

    task automatic trapEntryTest();
        int errorsBefore;
        errorsBefore = errorCount;
        for (int i = 0; i < 8; i++) begin
            access(1'b1, csrWrite, csrNumMstatus, randomWord());
            access(1'b1, csrWrite, csrNumMtvec, randomWord());
            trapEntry();
            readCsr(csrNumMepc);
            readCsr(csrNumMtval);
            readCsr(csrNumMcause);
            readCsr(csrNumMstatus);
        end
        reportTest("trap entry", errorsBefore);
    endtask

    task automatic mretTest();
        int errorsBefore;
        errorsBefore = errorCount;
        for (int i = 0; i < 8; i++) begin
            access(1'b1, csrWrite, csrNumMstatus, randomWord());
            trapEntry();
            driveIdle();
            trapReq.triggerExcpt = 1'b1;
            trapReq.cause = causeMret;
            cycleStep();
            readCsr(csrNumMstatus);
        end
        reportTest("mret", errorsBefore);
    endtask

    task automatic interruptTest();
        int errorsBefore;
        errorsBefore = errorCount;
        for (int i = 0; i < 20; i++) begin
            access(1'b1, csrWrite, csrNumMie, randomWord());
            access(1'b1, csrWrite, csrNumMstatus, randomWord());
            repeat (2) begin
                reqTimerInterrupt = 1'(randomWord());
                reqExternalInterrupt = 1'(randomWord());
                externalInterruptCode = 1'(randomWord());
                readCsr(csrNumMip);
            end
            driveIdle();
            trapReq.triggerInterrupt = 1'b1;
            trapReq.interruptCode = 4'(randomWord());
            trapReq.interruptRetAddr = randomWord();
            cycleStep();
            readCsr(csrNumMcause);
            readCsr(csrNumMepc);
        end
        reportTest("interrupts", errorsBefore);
    endtask

    task automatic counterTest();
        int errorsBefore;
        errorsBefore = errorCount;
        access(1'b1, csrWrite, csrNumMcycle, 32'hFFFF_FFFF);
        access(1'b1, csrWrite, csrNumMinstret, 32'hFFFF_FFFF);
        for (int i = 0; i < 40; i++) begin
            commitNum = 2'(randomWord());
            case (i % 4)
                0: readCsr(csrNumMcycleh);
                1: readCsr(csrNumMinstret);
                2: readCsr(csrNumMinstreth);
                default: readCsr(csrNumMcycle);
            endcase
        end
        commitNum = '0;
        reportTest("counters", errorsBefore);
    endtask

    task automatic unimplementedTest();
        int errorsBefore;
        logic [11:0] number;
        errorsBefore = errorCount;
        for (int i = 0; i < 10; i++) begin
            // 0x7C0 to 0x7FF hold no implemented CSR
            number = 12'h7C0 + 12'(randomWord() % 32'd64);
            access(1'b1, randomOp(), number, randomWord());
            readCsr(number);
        end
        for (int i = 0; i < 8; i++) begin
            readCsr(stateReg(i));
        end
        reportTest("unimplemented CSR", errorsBefore);
    endtask

    initial begin
        clk = 1'b0;
        arstN = 1'b0;
        commitNum = '0;
        reqTimerInterrupt = 1'b0;
        reqExternalInterrupt = 1'b0;
        externalInterruptCode = 1'b0;
        driveIdle();
        {mStatus, mMie, mMtvec, mMepc, mMscratch, mMtval, mMcause} = '0;
        {mCycle, mInstret, mCommitReg, mTimer, mExt, mExtCode} = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        writeOpsTest();
        trapEntryTest();
        mretTest();
        interruptTest();
        counterTest();
        unimplementedTest();
        $display("tests: %0d, failed: %0d, checks: %0d, errors: %0d",
                 testCount, failedTests, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
src/csrPkg.sv
src/csrRegFile.sv
src/csrCounters.sv
src/csrAccessMerge.sv
src/csrUnit.sv
testbench/csrUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the csrUnit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module csrUnitTb -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VcsrUnitTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "PASS: all tests"; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1
